// File: common/uart_pkg.sv
// Serial framing for the 8N1 link
package uart_pkg;

    // Clock cycles spent on each serial bit
    localparam int CLKS_PER_BIT = 16;

    // Payload bits per frame
    localparam int DATA_BITS = 8;

    // One data byte on the link or the host bus
    typedef logic [DATA_BITS-1:0] byte_t;

endpackage

// File: common/periph_pkg.sv
// Host register map and link protocol codes
package periph_pkg;

    // ----------------------------------------------------------------------
    // Register map
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        KEY_CODE  = 3'd0,
        CONTROL   = 3'd1,
        STATUS    = 3'd2,
        RX_BUFFER = 3'd3,
        TX_BUFFER = 3'd4
    } reg_addr_e;

    // Signal code in the upper nibble, anything else is a plain byte
    typedef enum logic [3:0] {
        KEY = 4'd1,
        CRC = 4'd2,
        RGC = 4'd3,
        BOS = 4'd4,
        DAT = 4'd5,
        EOS = 4'd6
    } sig_code_e;

    // Control register bits
    localparam int CTL_IRQ_EN = 0;

    // Status register bits
    localparam int ST_KEY_RDY  = 0;
    localparam int ST_BOS      = 1;
    localparam int ST_DAT      = 2;
    localparam int ST_EOS      = 3;
    localparam int ST_BYT      = 4;
    localparam int ST_CLI_GRNT = 5;
    localparam int ST_TXF      = 6;

    // Flags the controller can set, bits 0 up to ST_BYT
    localparam int EVT_FLAGS = ST_BYT + 1;

    // ----------------------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic            write;
        reg_addr_e       addr;
        uart_pkg::byte_t wdata;
    } host_req_t;

    typedef struct packed {
        logic                 rx_store;
        logic                 key_store;
        uart_pkg::byte_t      data;
        logic [EVT_FLAGS-1:0] flag_set;
        logic                 grant;
    } link_event_t;

endpackage

// File: serial/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
    input  logic            clock,
    input  logic            reset,
    input  uart_pkg::byte_t data_i,
    input  logic            valid_i,
    output logic            ready_o,
    output logic            tx_o
);
    import uart_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e                       state_q;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_q;
    logic [$clog2(DATA_BITS)-1:0]    bit_cnt_q;
    byte_t                           shift_q;
    logic                            bit_end;

    assign ready_o = (state_q == TX_IDLE);
    assign bit_end = (clk_cnt_q == CLKS_PER_BIT - 1);

    // ----------------------------------------------------------------------
    // Frame sequencing
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            state_q   <= TX_IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            tx_o      <= 1'b1;
        end else if (state_q == TX_IDLE) begin
            // Start bit goes out right after the transfer
            if (valid_i) begin
                tx_o      <= 1'b0;
                clk_cnt_q <= '0;
                state_q   <= TX_START;
            end
        end else if (!bit_end) begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end else begin
            clk_cnt_q <= '0;
            case (state_q)
                TX_START: begin
                    tx_o      <= shift_q[0];
                    bit_cnt_q <= '0;
                    state_q   <= TX_DATA;
                end
                TX_DATA: begin
                    if (bit_cnt_q == DATA_BITS - 1) begin
                        // Stop bit
                        tx_o    <= 1'b1;
                        state_q <= TX_STOP;
                    end else begin
                        tx_o      <= shift_q[0];
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // LSB first, next bit always in shift_q[0]
    always_ff @(posedge clock) begin
        if (ready_o && valid_i) begin
            shift_q <= data_i;
        end else if (bit_end && (state_q == TX_START || state_q == TX_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    // Requester holds its request until the transmitter takes it
    a_valid_held : assert property (@(posedge clock) disable iff (!reset)
        valid_i && !ready_o |=> valid_i);

endmodule

// File: serial/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
    input  logic            clock,
    input  logic            reset,
    input  logic            rx_i,
    output uart_pkg::byte_t data_o,
    output logic            strobe_o
);
    import uart_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e                       state_q;
    logic [1:0]                      sync_q;
    logic                            last_q;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_q;
    logic [$clog2(DATA_BITS)-1:0]    bit_cnt_q;
    logic                            line;
    logic                            fall;
    logic                            bit_end;

    // Synchronized line and its falling edge
    assign line    = sync_q[1];
    assign fall    = last_q && !line;
    assign bit_end = (clk_cnt_q == CLKS_PER_BIT - 1);

    // ----------------------------------------------------------------------
    // Frame sequencing
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            sync_q    <= 2'b11;
            last_q    <= 1'b1;
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            strobe_o  <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], rx_i};
            last_q   <= line;
            strobe_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (fall) begin
                        clk_cnt_q <= '0;
                        state_q   <= RX_START;
                    end
                end
                RX_START: begin
                    // Half a bit in, start must still read low
                    if (clk_cnt_q == CLKS_PER_BIT / 2 - 1) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= '0;
                        state_q   <= line ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt_q <= '0;
                        if (bit_cnt_q == DATA_BITS - 1) begin
                            state_q <= RX_STOP;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: begin
                    // Mid stop bit, bad frames are dropped here
                    if (bit_end) begin
                        clk_cnt_q <= '0;
                        strobe_o  <= line;
                        state_q   <= RX_IDLE;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // Shift in from the top, LSB arrives first
    always_ff @(posedge clock) begin
        if (state_q == RX_DATA && bit_end) begin
            data_o <= {line, data_o[DATA_BITS-1:1]};
        end
    end

endmodule

// File: src/tx_arbiter.sv
`timescale 1ns/1ns

module tx_arbiter (
    input  logic            clock,
    input  logic            reset,
    input  uart_pkg::byte_t sig_data_i,
    input  logic            sig_valid_i,
    output logic            sig_ready_o,
    input  uart_pkg::byte_t host_data_i,
    input  logic            host_valid_i,
    output logic            host_ready_o,
    output uart_pkg::byte_t data_o,
    output logic            valid_o,
    input  logic            ready_i
);
    // Last transfer went to the host side
    logic last_host_q;
    logic pick_host;

    // Host wins alone, or on a tie when the signal side went last
    assign pick_host    = host_valid_i && (!sig_valid_i || !last_host_q);
    assign data_o       = pick_host ? host_data_i : sig_data_i;
    assign valid_o      = sig_valid_i || host_valid_i;
    assign host_ready_o = ready_i && pick_host;
    assign sig_ready_o  = ready_i && !pick_host;

    always_ff @(posedge clock) begin
        if (!reset) begin
            last_host_q <= 1'b0;
        end else if (valid_o && ready_i) begin
            last_host_q <= pick_host;
        end
    end

    // Grant byte request left waiting stays raised until it is served
    a_sig_held : assert property (@(posedge clock) disable iff (!reset)
        sig_valid_i && !sig_ready_o |=> sig_valid_i);

endmodule

// File: src/reg_bank.sv
`timescale 1ns/1ns

module reg_bank (
    input  logic                   clock,
    input  logic                   reset,
    input  periph_pkg::host_req_t  host_i,
    output uart_pkg::byte_t        rdata_o,
    input  periph_pkg::link_event_t event_i,
    output uart_pkg::byte_t        tx_data_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i,
    output logic                   irq_o
);
    import uart_pkg::*;
    import periph_pkg::*;

    byte_t                key_code_q;
    byte_t                control_q;
    byte_t                rx_buf_q;
    byte_t                tx_buf_q;
    logic [EVT_FLAGS-1:0] flags_q;
    logic                 txf_q;
    logic [EVT_FLAGS-1:0] clear_mask;
    byte_t                status_rd;

    // Write-one-to-clear on the event flags only
    assign clear_mask = (host_i.write && host_i.addr == STATUS) ?
                        host_i.wdata[EVT_FLAGS-1:0] : '0;

    assign tx_data_o  = tx_buf_q;
    assign tx_valid_o = txf_q;
    assign irq_o      = flags_q[ST_KEY_RDY] && control_q[CTL_IRQ_EN];

    // ----------------------------------------------------------------------
    // Register updates
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            key_code_q <= '0;
            control_q  <= '0;
            rx_buf_q   <= '0;
            tx_buf_q   <= '0;
            flags_q    <= '0;
            txf_q      <= 1'b0;
        end else begin
            // Event sets beat a host clear in the same cycle
            flags_q <= (flags_q & ~clear_mask) | event_i.flag_set;
            if (event_i.rx_store) begin
                rx_buf_q <= event_i.data;
            end
            if (event_i.key_store) begin
                key_code_q <= event_i.data;
            end
            if (host_i.write && host_i.addr == CONTROL) begin
                control_q <= host_i.wdata;
            end
            // New write reloads the buffer, else the transfer empties it
            if (host_i.write && host_i.addr == TX_BUFFER) begin
                tx_buf_q <= host_i.wdata;
                txf_q    <= 1'b1;
            end else if (txf_q && tx_ready_i) begin
                txf_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------
    always_comb begin
        status_rd                       = '0;
        status_rd[EVT_FLAGS-1:0]        = flags_q;
        status_rd[ST_CLI_GRNT]          = event_i.grant;
        status_rd[ST_TXF]               = txf_q;
    end

    always_comb begin
        case (host_i.addr)
            KEY_CODE:  rdata_o = key_code_q;
            CONTROL:   rdata_o = control_q;
            STATUS:    rdata_o = status_rd;
            RX_BUFFER: rdata_o = rx_buf_q;
            TX_BUFFER: rdata_o = tx_buf_q;
            default:   rdata_o = '0;
        endcase
    end

endmodule

// File: src/link_controller.sv
`timescale 1ns/1ns

module link_controller (
    input  logic                    clock,
    input  logic                    reset,
    input  uart_pkg::byte_t         rx_data_i,
    input  logic                    rx_strobe_i,
    output periph_pkg::link_event_t event_o,
    output uart_pkg::byte_t         sig_data_o,
    output logic                    sig_valid_o,
    input  logic                    sig_ready_i
);
    import periph_pkg::*;

    typedef enum logic [1:0] {LC_IDLE, LC_KEY_WAIT, LC_CLIENT} mode_e;

    mode_e      mode_q;
    logic [3:0] code;
    logic       sig_req;

    assign code = rx_data_i[7:4];

    // Only grant byte ever sent from here
    assign sig_data_o = {RGC, 4'h0};

    // Control request seen while idle
    assign sig_req = rx_strobe_i && mode_q == LC_IDLE && code == CRC;

    // ----------------------------------------------------------------------
    // Byte classification
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            mode_q  <= LC_IDLE;
            event_o <= '0;
        end else begin
            // Strobes last one cycle, grant is a level
            event_o.rx_store  <= 1'b0;
            event_o.key_store <= 1'b0;
            event_o.flag_set  <= '0;
            if (rx_strobe_i) begin
                event_o.data <= rx_data_i;
                case (mode_q)
                    LC_IDLE: begin
                        if (code == KEY) begin
                            mode_q <= LC_KEY_WAIT;
                        end else if (code == CRC) begin
                            event_o.grant <= 1'b1;
                            mode_q        <= LC_CLIENT;
                        end else begin
                            event_o.rx_store <= 1'b1;
                        end
                    end
                    LC_KEY_WAIT: begin
                        // Whole byte is the key code
                        event_o.key_store            <= 1'b1;
                        event_o.flag_set[ST_KEY_RDY] <= 1'b1;
                        mode_q                       <= LC_IDLE;
                    end
                    default: begin
                        event_o.rx_store <= 1'b1;
                        case (code)
                            BOS: event_o.flag_set[ST_BOS] <= 1'b1;
                            DAT: event_o.flag_set[ST_DAT] <= 1'b1;
                            EOS: begin
                                // End of stream hands control back
                                event_o.flag_set[ST_EOS] <= 1'b1;
                                event_o.grant            <= 1'b0;
                                mode_q                   <= LC_IDLE;
                            end
                            default: event_o.flag_set[ST_BYT] <= 1'b1;
                        endcase
                    end
                endcase
            end
        end
    end

    // Grant byte request, held until the arbiter takes it
    always_ff @(posedge clock) begin
        if (!reset) begin
            sig_valid_o <= 1'b0;
        end else if (sig_req) begin
            sig_valid_o <= 1'b1;
        end else if (sig_ready_i) begin
            sig_valid_o <= 1'b0;
        end
    end

    // Previous RGC must be on its way before another CRC is granted
    a_no_double_req : assert property (@(posedge clock) disable iff (!reset)
        sig_req |-> !sig_valid_o || sig_ready_i);

endmodule

// File: src/uart_periph_top.sv
`timescale 1ns/1ns

module uart_periph_top (
    input  logic                clock,
    input  logic                reset,
    input  periph_pkg::host_req_t host_i,
    output uart_pkg::byte_t     rdata_o,
    input  logic                rx_i,
    output logic                tx_o,
    output logic                irq_o
);
    import uart_pkg::*;
    import periph_pkg::*;

    // Receive path
    byte_t       rx_data;
    logic        rx_strobe;
    link_event_t link_event;

    // Byte sources toward the arbiter
    byte_t sig_data;
    logic  sig_valid;
    logic  sig_ready;
    byte_t host_data;
    logic  host_valid;
    logic  host_ready;

    // Arbiter to transmitter
    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;

    reg_bank reg_bank0 (
        .clock      (clock),
        .reset      (reset),
        .host_i     (host_i),
        .rdata_o    (rdata_o),
        .event_i    (link_event),
        .tx_data_o  (host_data),
        .tx_valid_o (host_valid),
        .tx_ready_i (host_ready),
        .irq_o      (irq_o)
    );

    link_controller link_ctrl0 (
        .clock       (clock),
        .reset       (reset),
        .rx_data_i   (rx_data),
        .rx_strobe_i (rx_strobe),
        .event_o     (link_event),
        .sig_data_o  (sig_data),
        .sig_valid_o (sig_valid),
        .sig_ready_i (sig_ready)
    );

    tx_arbiter tx_arb0 (
        .clock        (clock),
        .reset        (reset),
        .sig_data_i   (sig_data),
        .sig_valid_i  (sig_valid),
        .sig_ready_o  (sig_ready),
        .host_data_i  (host_data),
        .host_valid_i (host_valid),
        .host_ready_o (host_ready),
        .data_o       (tx_data),
        .valid_o      (tx_valid),
        .ready_i      (tx_ready)
    );

    uart_tx uart_tx0 (
        .clock   (clock),
        .reset   (reset),
        .data_i  (tx_data),
        .valid_i (tx_valid),
        .ready_o (tx_ready),
        .tx_o    (tx_o)
    );

    uart_rx uart_rx0 (
        .clock    (clock),
        .reset    (reset),
        .rx_i     (rx_i),
        .data_o   (rx_data),
        .strobe_o (rx_strobe)
    );

endmodule

// File: test/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input  logic            clock,
    input  logic            reset,
    input  logic            tx_i,
    input  uart_pkg::byte_t rdata_i,
    input  logic            irq_i,
    output int              frames_o,
    output int              errors_o
);
    import uart_pkg::*;

    // Bytes the reference model expects on the transmit line, in order
    byte_t exp_q [$];
    string test_name;
    int    checks;
    int    test_errs;
    int    tests_run;
    int    tests_failed;

    initial begin
        frames_o     = 0;
        errors_o     = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "none";
    end

    function automatic void add_expected(input byte_t b);
        exp_q.push_back(b);
    endfunction

    task automatic compare(input string what, input byte_t expected, input byte_t actual);
        checks++;
        if (actual !== expected) begin
            errors_o++;
            test_errs++;
            $display("Fail %s: %s expected 0x%02h actual 0x%02h",
                     test_name, what, expected, actual);
        end
    endtask

    // Register read, rdata settles by the falling edge
    task automatic check_reg(input string what, input byte_t expected);
        @(negedge clock);
        compare(what, expected, rdata_i);
    endtask

    task automatic check_irq(input logic expected);
        @(negedge clock);
        compare("irq", {7'b0, expected}, {7'b0, irq_i});
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (exp_q.size() != 0) begin
            errors_o++;
            test_errs++;
            $display("%s: %0d expected bytes never appeared on the tx line",
                     test_name, exp_q.size());
            exp_q.delete();
        end
        if (test_errs == 0) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic report();
        $display("Tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors_o);
    endtask

    // ----------------------------------------------------------------------
    // Transmit line decoder, independent of uart_tx
    // ----------------------------------------------------------------------
    initial begin : decode_tx
        byte_t value;
        int    n;
        forever begin
            @(negedge clock);
            if (reset && !tx_i) begin
                // Move to mid start bit, then one bit time per sample
                repeat (CLKS_PER_BIT / 2) @(negedge clock);
                for (n = 0; n < DATA_BITS; n++) begin
                    repeat (CLKS_PER_BIT) @(negedge clock);
                    value[n] = tx_i;
                end
                repeat (CLKS_PER_BIT) @(negedge clock);
                if (!tx_i) begin
                    errors_o++;
                    test_errs++;
                    $display("Stop bit read low on the tx line during %s", test_name);
                end
                if (exp_q.size() == 0) begin
                    errors_o++;
                    test_errs++;
                    $display("Unexpected byte 0x%02h on the tx line during %s",
                             value, test_name);
                end else begin
                    compare("tx byte", exp_q.pop_front(), value);
                end
                frames_o++;
            end
        end
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ns

module tb_top;
    import uart_pkg::*;
    import periph_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam byte_t STREAM_FLAGS =
        byte_t'((1 << ST_BOS) | (1 << ST_DAT) | (1 << ST_EOS) | (1 << ST_BYT));

    typedef enum {M_IDLE, M_KEY_WAIT, M_CLIENT} ref_mode_e;

    logic      clock;
    logic      reset;
    host_req_t host;
    logic      rx_i;
    byte_t     rdata;
    logic      tx;
    logic      irq;
    int        frames;
    int        errors;
    int        cycles;

    // Reference model state
    ref_mode_e ref_mode;
    byte_t     ref_key;
    byte_t     ref_ctrl;
    byte_t     ref_rx;
    byte_t     ref_txbuf;
    logic [4:0] ref_flags;
    logic      ref_grant;
    logic      ref_txf;
    int        ref_frames;
    byte_t     stream [4];
    byte_t     host_byte;

    uart_periph_top dut0 (
        .clock   (clock),
        .reset   (reset),
        .host_i  (host),
        .rdata_o (rdata),
        .rx_i    (rx_i),
        .tx_o    (tx),
        .irq_o   (irq)
    );

    tb_checker chk0 (
        .clock    (clock),
        .reset    (reset),
        .tx_i     (tx),
        .rdata_i  (rdata),
        .irq_i    (irq),
        .frames_o (frames),
        .errors_o (errors)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic void push_expected_tx(input byte_t b);
        ref_frames++;
        chk0.add_expected(b);
    endfunction

    function automatic byte_t ref_status();
        return {1'b0, ref_txf, ref_grant, ref_flags};
    endfunction

    function automatic logic ref_irq();
        return ref_flags[ST_KEY_RDY] && ref_ctrl[CTL_IRQ_EN];
    endfunction

    // One received byte through the link protocol
    function automatic void predict_rx(input byte_t b);
        case (ref_mode)
            M_IDLE: begin
                if (b[7:4] == KEY) begin
                    ref_mode = M_KEY_WAIT;
                end else if (b[7:4] == CRC) begin
                    ref_grant = 1'b1;
                    ref_mode  = M_CLIENT;
                    push_expected_tx({RGC, 4'h0});
                end else begin
                    ref_rx = b;
                end
            end
            M_KEY_WAIT: begin
                ref_key               = b;
                ref_flags[ST_KEY_RDY] = 1'b1;
                ref_mode              = M_IDLE;
            end
            default: begin
                ref_rx = b;
                if (b[7:4] == BOS) begin
                    ref_flags[ST_BOS] = 1'b1;
                end else if (b[7:4] == DAT) begin
                    ref_flags[ST_DAT] = 1'b1;
                end else if (b[7:4] == EOS) begin
                    ref_flags[ST_EOS] = 1'b1;
                    ref_grant         = 1'b0;
                    ref_mode          = M_IDLE;
                end else begin
                    ref_flags[ST_BYT] = 1'b1;
                end
            end
        endcase
    endfunction

    function automatic void predict_write(input reg_addr_e addr, input byte_t data);
        if (addr == CONTROL) begin
            ref_ctrl = data;
        end else if (addr == STATUS) begin
            ref_flags = ref_flags & ~data[4:0];
        end else if (addr == TX_BUFFER) begin
            ref_txbuf = data;
            ref_txf   = 1'b1;
            push_expected_tx(data);
        end
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    function automatic byte_t sig_byte(input logic [3:0] code);
        byte_t r;
        r = byte_t'($urandom);
        return {code, r[3:0]};
    endfunction

    // Random byte whose upper nibble is no signal code
    function automatic byte_t plain_byte();
        byte_t b;
        b = byte_t'($urandom);
        while (b[7:4] >= KEY && b[7:4] <= EOS) begin
            b = byte_t'($urandom);
        end
        return b;
    endfunction

    // 8N1 frame on rx_i with the LSB first and a short margin after
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clock);
            rx_i <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
        predict_rx(b);
        repeat (4) @(posedge clock);
    endtask

    task automatic host_write(input reg_addr_e addr, input byte_t data);
        @(posedge clock);
        host.write <= 1'b1;
        host.addr  <= addr;
        host.wdata <= data;
        @(posedge clock);
        host.write <= 1'b0;
        predict_write(addr, data);
    endtask

    task automatic read_check(input string what, input reg_addr_e addr,
                              input byte_t expected);
        @(posedge clock);
        host.addr <= addr;
        chk0.check_reg(what, expected);
    endtask

    // Waits for every predicted frame and then one idle frame time
    task automatic wait_tx_done();
        while (frames < ref_frames) begin
            @(posedge clock);
        end
        repeat (10 * CLKS_PER_BIT) @(posedge clock);
        ref_txf = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        reset      = 1'b0;
        host       = '0;
        rx_i       = 1'b1;
        ref_mode   = M_IDLE;
        ref_key    = '0;
        ref_ctrl   = '0;
        ref_rx     = '0;
        ref_txbuf  = '0;
        ref_flags  = '0;
        ref_grant  = 1'b0;
        ref_txf    = 1'b0;
        ref_frames = 0;
        void'($urandom(9051));
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        repeat (4) @(posedge clock);

        chk0.start_test("host_transmit");
        host_write(TX_BUFFER, byte_t'($urandom));
        wait_tx_done();
        read_check("status", STATUS, ref_status());
        read_check("tx buffer", TX_BUFFER, ref_txbuf);
        chk0.finish_test();

        chk0.start_test("key_code");
        send_byte(sig_byte(KEY));
        send_byte(byte_t'($urandom));
        read_check("key code", KEY_CODE, ref_key);
        read_check("status", STATUS, ref_status());
        chk0.check_irq(ref_irq());
        host_write(CONTROL, 8'h01);
        read_check("control", CONTROL, ref_ctrl);
        chk0.check_irq(ref_irq());
        host_write(STATUS, byte_t'(1 << ST_KEY_RDY));
        read_check("status after clear", STATUS, ref_status());
        chk0.check_irq(ref_irq());
        chk0.finish_test();

        chk0.start_test("control_grant");
        send_byte(sig_byte(CRC));
        read_check("status", STATUS, ref_status());
        wait_tx_done();
        chk0.finish_test();

        chk0.start_test("stream_flags");
        stream[0] = sig_byte(BOS);
        stream[1] = sig_byte(DAT);
        stream[2] = plain_byte();
        stream[3] = sig_byte(EOS);
        foreach (stream[i]) begin
            send_byte(stream[i]);
            read_check("rx buffer", RX_BUFFER, ref_rx);
            read_check("status", STATUS, ref_status());
            host_write(STATUS, STREAM_FLAGS);
        end
        // Granted again after the stream ended
        send_byte(sig_byte(CRC));
        read_check("status regrant", STATUS, ref_status());
        wait_tx_done();
        send_byte(sig_byte(EOS));
        read_check("status release", STATUS, ref_status());
        host_write(STATUS, STREAM_FLAGS);
        chk0.finish_test();

        chk0.start_test("contention");
        host_byte = byte_t'($urandom);
        fork
            send_byte(sig_byte(CRC));
            begin
                repeat (5 * CLKS_PER_BIT) @(posedge clock);
                host_write(TX_BUFFER, host_byte);
            end
        join
        wait_tx_done();
        read_check("status", STATUS, ref_status());
        read_check("tx buffer", TX_BUFFER, ref_txbuf);
        chk0.finish_test();

        chk0.report();
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Hang guard at roughly eight times the frame traffic of all tests
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles without finishing", cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: tb.f
common/uart_pkg.sv
common/periph_pkg.sv
serial/uart_tx.sv
serial/uart_rx.sv
src/tx_arbiter.sv
src/reg_bank.sv
src/link_controller.sv
src/uart_periph_top.sv
test/tb_checker.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: uart_periph

sources:
  - common/uart_pkg.sv
  - common/periph_pkg.sv
  - serial/uart_tx.sv
  - serial/uart_rx.sv
  - src/tx_arbiter.sv
  - src/reg_bank.sv
  - src/link_controller.sv
  - src/uart_periph_top.sv
  - target: test
    files:
      - test/tb_checker.sv
      - test/tb_top.sv
